// File: src/mmu_defs.svh
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// tlb geometry

// number of entries in the tlb
`define MMU_TLB_ENTRIES 16

// index width covering MMU_TLB_ENTRIES
`define MMU_TLB_IDX_W 4

`endif

// File: src/mmu_pkg.sv
`default_nettype none

`include "mmu_defs.svh"

package mmu_pkg;

    // encodings follow the core's access type numbering
    typedef enum logic [1:0] {
        mem_load  = 2'd0,
        mem_store = 2'd1,
        mem_fetch = 2'd2
    } mem_type_e;

    typedef enum logic [2:0] {
        exc_none,
        exc_refill,
        exc_inv_load,
        exc_inv_store,
        exc_inv_fetch,
        exc_priv,
        exc_modify
    } exc_code_e;

    typedef enum logic [1:0] {
        inv_all,
        inv_asid,
        inv_asid_va
    } inv_op_e;

    typedef enum logic [1:0] {
        ctrl_mode,
        ctrl_dmw0,
        ctrl_dmw1
    } ctrl_target_e;

    typedef struct packed {
        logic [19:0] pfn;
        logic [1:0]  mat;
        logic [1:0]  plv;
        logic        d;
        logic        v;
    } tlb_page_t;

    // huge set means a 2 MB page pair
    typedef struct packed {
        logic [18:0] vpn2;
        logic [9:0]  asid;
        logic        huge;
        logic        g;
        logic        e;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] vaddr;
        logic [9:0]  asid;
        logic [1:0]  plv;
        mem_type_e   mem_type;
    } lookup_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        logic [1:0]  mat;
        exc_code_e   exc;
    } lookup_rsp_t;

    typedef struct packed {
        logic                      valid;
        logic [`MMU_TLB_IDX_W-1:0] index;
        tlb_entry_t                entry;
    } tlb_write_t;

    typedef struct packed {
        logic       valid;
        tlb_entry_t entry;
    } tlb_read_t;

    typedef struct packed {
        logic        valid;
        inv_op_e     op;
        logic [9:0]  asid;
        logic [31:0] vaddr;
    } inv_req_t;

    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [1:0] mat;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_t;

    typedef struct packed {
        logic         valid;
        ctrl_target_e target;
        logic         da;
        logic [1:0]   da_mat;
        dmw_t         dmw;
    } ctrl_write_t;

    // vpn compare at the entry's own page size
    function automatic logic vpn_hit(tlb_entry_t ent, logic [31:0] va);
        if (ent.huge) begin
            return ent.vpn2[18:9] == va[31:22];
        end
        return ent.vpn2 == va[31:13];
    endfunction

endpackage

`default_nettype wire

// File: src/xlate_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module xlate_ctrl_regs import mmu_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire ctrl_write_t ctrl,
    input  wire logic [31:0] vaddr,
    input  wire logic [1:0]  plv,
    output logic             da_mode,
    output logic [1:0]       da_mat,
    output logic             dmw_hit,
    output logic [1:0]       dmw_mat,
    output logic [2:0]       dmw_pseg
);

    dmw_t dmw0_q;
    dmw_t dmw1_q;
    logic hit0;
    logic hit1;

    // levels 1 and 2 have no enable bit, so they never match a window
    function automatic logic window_hit(dmw_t w, logic [2:0] seg, logic [1:0] lvl);
        logic lvl_ok;
        lvl_ok = (lvl == 2'd0 && w.plv0) || (lvl == 2'd3 && w.plv3);
        return lvl_ok && (w.vseg == seg);
    endfunction

    // direct address with both windows disabled out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            da_mode <= 1'b1;
            da_mat  <= 2'd0;
            dmw0_q  <= '0;
            dmw1_q  <= '0;
        end else if (ctrl.valid) begin
            case (ctrl.target)
                ctrl_mode: begin
                    da_mode <= ctrl.da;
                    da_mat  <= ctrl.da_mat;
                end
                ctrl_dmw0: dmw0_q <= ctrl.dmw;
                ctrl_dmw1: dmw1_q <= ctrl.dmw;
                default: ;
            endcase
        end
    end

    always_comb begin
        hit0    = window_hit(dmw0_q, vaddr[31:29], plv);
        hit1    = window_hit(dmw1_q, vaddr[31:29], plv);
        dmw_hit = hit0 || hit1;
        // window 0 wins on overlap
        if (hit0) begin
            dmw_mat  = dmw0_q.mat;
            dmw_pseg = dmw0_q.pseg;
        end else begin
            dmw_mat  = dmw1_q.mat;
            dmw_pseg = dmw1_q.pseg;
        end
    end

endmodule

`default_nettype wire

// File: src/tlb_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module tlb_entry_array import mmu_pkg::*; #(
    parameter int NUM_ENTRIES = `MMU_TLB_ENTRIES
) (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire tlb_write_t                wr,
    input  wire logic                      read_valid,
    input  wire logic [`MMU_TLB_IDX_W-1:0] read_index,
    input  wire inv_req_t                  inv,
    output tlb_read_t                      rd,
    output tlb_entry_t [NUM_ENTRIES-1:0]   entries
);

    // payload storage; the live bits sit in e_q
    tlb_entry_t             mem [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] e_q;
    logic [NUM_ENTRIES-1:0] inv_hit;
    logic                   rd_valid_q;
    tlb_entry_t             rd_entry_q;

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            entries[i]   = mem[i];
            entries[i].e = e_q[i];
        end
    end

    // global entries survive the asid based rules
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            case (inv.op)
                inv_all:
                    inv_hit[i] = 1'b1;
                inv_asid:
                    inv_hit[i] = !mem[i].g && (mem[i].asid == inv.asid);
                inv_asid_va:
                    inv_hit[i] = !mem[i].g && (mem[i].asid == inv.asid)
                                 && vpn_hit(mem[i], inv.vaddr);
                default:
                    inv_hit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            e_q <= '0;
        end else if (wr.valid) begin
            e_q[wr.index] <= wr.entry.e;
        end else if (inv.valid) begin
            e_q <= e_q & ~inv_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem[wr.index] <= wr.entry;
        end
    end

    // read-back
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= read_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (read_valid) begin
            rd_entry_q <= entries[read_index];
        end
    end

    always_comb begin
        rd.valid = rd_valid_q;
        rd.entry = rd_entry_q;
    end

    // the two software ports share the e_q update path
    assert property (@(posedge clk) disable iff (reset) !(wr.valid && inv.valid))
        else $error("tlb write and invalidate in the same cycle");

endmodule

`default_nettype wire

// File: src/tlb_match.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module tlb_match import mmu_pkg::*; (
    input  wire logic                             clk,
    input  wire logic                             reset,
    input  wire logic                             valid,
    input  wire tlb_entry_t [`MMU_TLB_ENTRIES-1:0] entries,
    input  wire logic [31:0]                      vaddr,
    input  wire logic [9:0]                       asid,
    output logic                                  hit,
    output tlb_page_t                             page,
    output logic                                  huge
);

    logic [`MMU_TLB_ENTRIES-1:0] hit_vec;
    tlb_entry_t                  sel;

    always_comb begin
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            hit_vec[i] = entries[i].e
                         && (entries[i].g || (entries[i].asid == asid))
                         && vpn_hit(entries[i], vaddr);
        end
    end

    // at most one entry hits, so a plain scan selects it
    always_comb begin
        sel = '0;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            if (hit_vec[i]) begin
                sel = entries[i];
            end
        end
    end

    assign hit  = |hit_vec;
    assign huge = sel.huge;
    // odd half picked by the bit just above the page offset
    assign page = (sel.huge ? vaddr[21] : vaddr[12]) ? sel.page1 : sel.page0;

    // relies on software never loading overlapping live entries
    assert property (@(posedge clk) disable iff (reset) valid |-> $onehot0(hit_vec))
        else $error("multiple tlb entries hit one lookup");

endmodule

`default_nettype wire

// File: src/addr_translate.sv
`timescale 1ns/1ps
`default_nettype none

module addr_translate import mmu_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire lookup_req_t req,
    input  wire logic        da_mode,
    input  wire logic [1:0]  da_mat,
    input  wire logic        dmw_hit,
    input  wire logic [1:0]  dmw_mat,
    input  wire logic [2:0]  dmw_pseg,
    input  wire logic        tlb_hit,
    input  wire tlb_page_t   page,
    input  wire logic        huge,
    output lookup_rsp_t      rsp
);

    logic        valid_q;
    logic [31:0] vaddr_q;
    logic [1:0]  plv_q;
    mem_type_e   mem_type_q;
    logic        da_mode_q;
    logic [1:0]  da_mat_q;
    logic        dmw_hit_q;
    logic [1:0]  dmw_mat_q;
    logic [2:0]  dmw_pseg_q;
    logic        tlb_hit_q;
    tlb_page_t   page_q;
    logic        huge_q;
    exc_code_e   inv_code;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    // request and all path results captured together
    always_ff @(posedge clk) begin
        if (req.valid) begin
            vaddr_q    <= req.vaddr;
            plv_q      <= req.plv;
            mem_type_q <= req.mem_type;
            da_mode_q  <= da_mode;
            da_mat_q   <= da_mat;
            dmw_hit_q  <= dmw_hit;
            dmw_mat_q  <= dmw_mat;
            dmw_pseg_q <= dmw_pseg;
            tlb_hit_q  <= tlb_hit;
            page_q     <= page;
            huge_q     <= huge;
        end
    end

    always_comb begin
        case (mem_type_q)
            mem_store: inv_code = exc_inv_store;
            mem_fetch: inv_code = exc_inv_fetch;
            default:   inv_code = exc_inv_load;
        endcase
    end

    always_comb begin
        rsp.valid = valid_q;
        rsp.exc   = exc_none;
        if (da_mode_q) begin
            rsp.paddr = vaddr_q;
            rsp.mat   = da_mat_q;
        end else if (dmw_hit_q) begin
            rsp.paddr = {dmw_pseg_q, vaddr_q[28:0]};
            rsp.mat   = dmw_mat_q;
        end else begin
            // 2 MB pages keep 21 offset bits
            rsp.paddr = huge_q ? {page_q.pfn[19:9], vaddr_q[20:0]}
                               : {page_q.pfn, vaddr_q[11:0]};
            rsp.mat   = page_q.mat;
            if (!tlb_hit_q) begin
                rsp.exc = exc_refill;
            end else if (!page_q.v) begin
                rsp.exc = inv_code;
            end else if (plv_q > page_q.plv) begin
                rsp.exc = exc_priv;
            end else if (mem_type_q == mem_store && !page_q.d) begin
                rsp.exc = exc_modify;
            end
        end
    end

    // fixed one cycle latency, no stalls
    assert property (@(posedge clk) disable iff (reset)
                     !$past(reset) |-> rsp.valid == $past(req.valid))
        else $error("lookup response latency broken");

endmodule

`default_nettype wire

// File: src/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module mmu_top import mmu_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire ctrl_write_t               ctrl,
    input  wire tlb_write_t                wr,
    input  wire logic                      read_valid,
    input  wire logic [`MMU_TLB_IDX_W-1:0] read_index,
    input  wire inv_req_t                  inv,
    input  wire lookup_req_t               lookup,
    output lookup_rsp_t                    rsp,
    output tlb_read_t                      rd
);

    wire logic                              da_mode;
    wire logic [1:0]                        da_mat;
    wire logic                              dmw_hit;
    wire logic [1:0]                        dmw_mat;
    wire logic [2:0]                        dmw_pseg;
    wire tlb_entry_t [`MMU_TLB_ENTRIES-1:0] entries;
    wire logic                              tlb_hit;
    wire tlb_page_t                         page;
    wire logic                              huge;

    xlate_ctrl_regs u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .vaddr    (lookup.vaddr),
        .plv      (lookup.plv),
        .da_mode  (da_mode),
        .da_mat   (da_mat),
        .dmw_hit  (dmw_hit),
        .dmw_mat  (dmw_mat),
        .dmw_pseg (dmw_pseg)
    );

    tlb_entry_array u_array (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .read_valid (read_valid),
        .read_index (read_index),
        .inv        (inv),
        .rd         (rd),
        .entries    (entries)
    );

    tlb_match u_match (
        .clk     (clk),
        .reset   (reset),
        .valid   (lookup.valid),
        .entries (entries),
        .vaddr   (lookup.vaddr),
        .asid    (lookup.asid),
        .hit     (tlb_hit),
        .page    (page),
        .huge    (huge)
    );

    addr_translate u_xlate (
        .clk      (clk),
        .reset    (reset),
        .req      (lookup),
        .da_mode  (da_mode),
        .da_mat   (da_mat),
        .dmw_hit  (dmw_hit),
        .dmw_mat  (dmw_mat),
        .dmw_pseg (dmw_pseg),
        .tlb_hit  (tlb_hit),
        .page     (page),
        .huge     (huge),
        .rsp      (rsp)
    );

endmodule

`default_nettype wire

// File: verif/mmu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module mmu_checker import mmu_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire ctrl_write_t               ctrl,
    input  wire tlb_write_t                wr,
    input  wire logic                      read_valid,
    input  wire logic [`MMU_TLB_IDX_W-1:0] read_index,
    input  wire inv_req_t                  inv,
    input  wire lookup_req_t               lookup,
    input  wire lookup_rsp_t               rsp,
    input  wire tlb_read_t                 rd,
    output logic                           busy,
    output int                             err_total,
    output int                             chk_total
);

    logic        m_da;
    logic [1:0]  m_da_mat;
    dmw_t        m_dmw [2];
    tlb_entry_t  m_ent [`MMU_TLB_ENTRIES];
    lookup_rsp_t exp_rsp;
    logic        exp_rd_valid;
    tlb_entry_t  exp_rd;
    int          mark_checks = 0;
    int          mark_errors = 0;

    assign busy = exp_rsp.valid || exp_rd_valid;

    // 2 MB pairs ignore vaddr bits 21:13
    function automatic logic same_vpn(tlb_entry_t ent, logic [31:0] va);
        logic [18:0] mask;
        mask = ent.huge ? 19'h7fe00 : 19'h7ffff;
        return ((ent.vpn2 ^ va[31:13]) & mask) == 19'd0;
    endfunction

    function automatic logic window_ok(dmw_t w, lookup_req_t req);
        return (w.vseg == req.vaddr[31:29])
               && ((req.plv == 2'd0 && w.plv0) || (req.plv == 2'd3 && w.plv3));
    endfunction

    function automatic lookup_rsp_t predict(lookup_req_t req);
        lookup_rsp_t r;
        tlb_page_t   pg;
        logic        hit;
        logic        huge;
        r       = '0;
        r.valid = 1'b1;
        r.exc   = exc_none;
        pg      = '0;
        hit     = 1'b0;
        huge    = 1'b0;
        if (m_da) begin
            r.paddr = req.vaddr;
            r.mat   = m_da_mat;
            return r;
        end
        // scan from window 1 down so window 0 has the last word
        for (int w = 1; w >= 0; w--) begin
            if (window_ok(m_dmw[w], req)) begin
                r.paddr = {m_dmw[w].pseg, req.vaddr[28:0]};
                r.mat   = m_dmw[w].mat;
                hit     = 1'b1;
            end
        end
        if (hit) begin
            return r;
        end
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            if (m_ent[i].e && (m_ent[i].g || m_ent[i].asid == req.asid)
                && same_vpn(m_ent[i], req.vaddr)) begin
                hit  = 1'b1;
                huge = m_ent[i].huge;
                if (huge ? req.vaddr[21] : req.vaddr[12]) begin
                    pg = m_ent[i].page1;
                end else begin
                    pg = m_ent[i].page0;
                end
            end
        end
        r.paddr = huge ? {pg.pfn[19:9], req.vaddr[20:0]} : {pg.pfn, req.vaddr[11:0]};
        r.mat   = pg.mat;
        if (!hit) begin
            r.exc = exc_refill;
        end else if (!pg.v) begin
            case (req.mem_type)
                mem_store: r.exc = exc_inv_store;
                mem_fetch: r.exc = exc_inv_fetch;
                default:   r.exc = exc_inv_load;
            endcase
        end else if (req.plv > pg.plv) begin
            r.exc = exc_priv;
        end else if (req.mem_type == mem_store && !pg.d) begin
            r.exc = exc_modify;
        end
        return r;
    endfunction

    task automatic update_model();
        if (ctrl.valid) begin
            case (ctrl.target)
                ctrl_mode: begin
                    m_da     = ctrl.da;
                    m_da_mat = ctrl.da_mat;
                end
                ctrl_dmw0: m_dmw[0] = ctrl.dmw;
                ctrl_dmw1: m_dmw[1] = ctrl.dmw;
                default: ;
            endcase
        end
        if (wr.valid) begin
            m_ent[wr.index] = wr.entry;
        end else if (inv.valid) begin
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                if (inv.op == inv_all) begin
                    m_ent[i].e = 1'b0;
                end else if (!m_ent[i].g && m_ent[i].asid == inv.asid
                             && (inv.op == inv_asid
                                 || (inv.op == inv_asid_va && same_vpn(m_ent[i], inv.vaddr)))) begin
                    m_ent[i].e = 1'b0;
                end
            end
        end
    endtask

    task automatic compare(input string name, input logic [83:0] exp, input logic [83:0] act);
        chk_total++;
        if (exp !== act) begin
            err_total++;
            $display("[ERROR] %0s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    // sample requests on the rising edge, compare on the falling edge
    always @(posedge clk or negedge clk) begin
        if (clk) begin
            if (reset) begin
                m_da         = 1'b1;
                m_da_mat     = 2'd0;
                m_dmw[0]     = '0;
                m_dmw[1]     = '0;
                exp_rsp      = '0;
                exp_rd_valid = 1'b0;
                err_total    = 0;
                chk_total    = 0;
                for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                    m_ent[i] = '0;
                end
            end else begin
                exp_rsp = '0;
                if (lookup.valid) begin
                    exp_rsp = predict(lookup);
                end
                exp_rd_valid = read_valid;
                if (read_valid) begin
                    exp_rd = m_ent[read_index];
                end
                update_model();
            end
        end else if (!reset) begin
            if (exp_rsp.valid || rsp.valid) begin
                compare("rsp.valid", 84'(exp_rsp.valid), 84'(rsp.valid));
            end
            if (exp_rsp.valid && rsp.valid) begin
                compare("rsp.exc", 84'(exp_rsp.exc), 84'(rsp.exc));
                // address and mat only mean something on success
                if (exp_rsp.exc == exc_none) begin
                    compare("rsp.paddr", 84'(exp_rsp.paddr), 84'(rsp.paddr));
                    compare("rsp.mat", 84'(exp_rsp.mat), 84'(rsp.mat));
                end
            end
            if (exp_rd_valid || rd.valid) begin
                compare("rd.valid", 84'(exp_rd_valid), 84'(rd.valid));
            end
            if (exp_rd_valid && rd.valid) begin
                compare("rd.entry", exp_rd, rd.entry);
            end
            exp_rsp.valid = 1'b0;
            exp_rd_valid  = 1'b0;
        end
    end

    task automatic report_test(input string name);
        $display("test %0s: %0d checks, %0d errors", name,
                 chk_total - mark_checks, err_total - mark_errors);
        mark_checks = chk_total;
        mark_errors = err_total;
    endtask

    task automatic report_totals();
        $display("total: %0d checks, %0d errors", chk_total, err_total);
    endtask

endmodule

`default_nettype wire

// File: verif/mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module mmu_tb import mmu_pkg::*; ();

    localparam int WAIT_LIMIT = 50;

    logic                      clk;
    logic                      reset;
    ctrl_write_t               ctrl;
    tlb_write_t                wr;
    logic                      read_valid;
    logic [`MMU_TLB_IDX_W-1:0] read_index;
    inv_req_t                  inv;
    lookup_req_t               lookup;
    lookup_rsp_t               rsp;
    tlb_read_t                 rd;
    logic                      busy;
    int                        err_total;
    int                        chk_total;
    integer                    seed;
    int                        skipped;
    int                        timeouts;
    // what the testbench believes may still be live in the TLB
    tlb_entry_t                shadow [`MMU_TLB_ENTRIES];

    mmu_top DUT (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .wr         (wr),
        .read_valid (read_valid),
        .read_index (read_index),
        .inv        (inv),
        .lookup     (lookup),
        .rsp        (rsp),
        .rd         (rd)
    );

    mmu_checker chk (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .wr         (wr),
        .read_valid (read_valid),
        .read_index (read_index),
        .inv        (inv),
        .lookup     (lookup),
        .rsp        (rsp),
        .rd         (rd),
        .busy       (busy),
        .err_total  (err_total),
        .chk_total  (chk_total)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic mem_type_e rand_mt();
        logic [31:0] r;
        r = rnd();
        case (r[1:0])
            2'd0:    return mem_load;
            2'd1:    return mem_store;
            default: return mem_fetch;
        endcase
    endfunction

    function automatic tlb_page_t rand_page();
        logic [31:0] r;
        tlb_page_t   pg;
        r      = rnd();
        pg.pfn = r[31:12];
        pg.mat = r[7:6];
        pg.plv = r[5:4];
        pg.d   = r[3];
        pg.v   = r[2:0] != 3'd0;
        return pg;
    endfunction

    // small vpn and asid ranges so that overlaps actually come up
    function automatic tlb_entry_t rand_entry();
        logic [31:0] r;
        tlb_entry_t  ent;
        r         = rnd();
        ent.vpn2  = {6'd0, r[3:0], 5'd0, r[7:4]};
        ent.asid  = {8'd0, r[9:8]};
        ent.huge  = r[10] & r[11];
        ent.g     = r[14:12] == 3'd0;
        ent.e     = r[17:15] != 3'd0;
        ent.page0 = rand_page();
        ent.page1 = rand_page();
        return ent;
    endfunction

    function automatic logic overlaps(tlb_entry_t a, tlb_entry_t b);
        logic [18:0] mask;
        mask = (a.huge || b.huge) ? 19'h7fe00 : 19'h7ffff;
        return a.e && b.e && (a.g || b.g || a.asid == b.asid)
               && ((a.vpn2 & mask) == (b.vpn2 & mask));
    endfunction

    function automatic logic [31:0] addr_in(tlb_entry_t ent);
        logic [31:0] r;
        r = rnd();
        if (ent.huge) begin
            return {ent.vpn2[18:9], r[21:0]};
        end
        return {ent.vpn2, r[12:0]};
    endfunction

    function automatic dmw_t make_dmw(logic plv0, logic plv3, logic [1:0] mat,
                                      logic [2:0] vseg, logic [2:0] pseg);
        dmw_t w;
        w.plv0 = plv0;
        w.plv3 = plv3;
        w.mat  = mat;
        w.vseg = vseg;
        w.pseg = pseg;
        return w;
    endfunction

    // advance to just after the next rising edge and drop all valids
    task automatic step();
        @(posedge clk);
        #1;
        ctrl.valid   = 1'b0;
        wr.valid     = 1'b0;
        read_valid   = 1'b0;
        inv.valid    = 1'b0;
        lookup.valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (busy) begin
            timeouts++;
            $display("timeout: responses still outstanding after %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic end_test(input string name);
        wait_drain();
        chk.report_test(name);
    endtask

    task automatic put_lookup(input logic [31:0] va, input logic [9:0] asid,
                              input logic [1:0] plv, input mem_type_e mt);
        lookup.valid    = 1'b1;
        lookup.vaddr    = va;
        lookup.asid     = asid;
        lookup.plv      = plv;
        lookup.mem_type = mt;
    endtask

    task automatic put_ctrl(input ctrl_target_e target, input logic da,
                            input logic [1:0] da_mat, input dmw_t w);
        ctrl.valid  = 1'b1;
        ctrl.target = target;
        ctrl.da     = da;
        ctrl.da_mat = da_mat;
        ctrl.dmw    = w;
    endtask

    task automatic put_inv(input inv_op_e op, input logic [9:0] asid, input logic [31:0] va);
        inv.valid = 1'b1;
        inv.op    = op;
        inv.asid  = asid;
        inv.vaddr = va;
    endtask

    // drops the write if it could hit alongside another live entry
    task automatic load_entry(input logic [`MMU_TLB_IDX_W-1:0] idx, input tlb_entry_t ent,
                              output logic done);
        done = 1'b1;
        for (int j = 0; j < `MMU_TLB_ENTRIES; j++) begin
            if (j != int'(idx) && overlaps(ent, shadow[j])) begin
                done = 1'b0;
            end
        end
        if (!done) begin
            skipped++;
        end else begin
            wr.valid    = 1'b1;
            wr.index    = idx;
            wr.entry    = ent;
            shadow[idx] = ent;
        end
    endtask

    task automatic lookup_near(input tlb_entry_t ent, input logic [1:0] plv,
                               input mem_type_e mt);
        logic [31:0] r;
        r = rnd();
        put_lookup(addr_in(ent), r[0] ? ent.asid : {8'd0, r[2:1]}, plv, mt);
        step();
    endtask

    task automatic read_all();
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            read_valid = 1'b1;
            read_index = i[`MMU_TLB_IDX_W-1:0];
            step();
        end
    endtask

    task automatic random_lookups(input int count, input logic mixed);
        logic [31:0] r;
        logic [31:0] r2;
        for (int i = 0; i < count; i++) begin
            r = rnd();
            if (mixed && r[1:0] == 2'd0) begin
                r2 = rnd();
                put_lookup(r2, {8'd0, r[3:2]}, r[5:4], rand_mt());
                step();
            end else if (mixed) begin
                lookup_near(shadow[r[7:4]], r[9:8], rand_mt());
            end else begin
                lookup_near(shadow[r[7:4]], 2'd0, mem_load);
            end
        end
    endtask

    initial begin
        logic [31:0]               r;
        logic [31:0]               r2;
        logic [`MMU_TLB_IDX_W-1:0] idx;
        tlb_entry_t                ent;
        logic                      done;
        seed       = 12;
        skipped    = 0;
        timeouts   = 0;
        clk        = 1'b0;
        reset      = 1'b1;
        ctrl       = '0;
        wr         = '0;
        read_valid = 1'b0;
        read_index = '0;
        inv        = '0;
        lookup     = '0;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < 40; i++) begin
            r  = rnd();
            r2 = rnd();
            // direct mode stays on with a new mat
            if (i == 20) begin
                put_ctrl(ctrl_mode, 1'b1, 2'd2, '0);
            end
            put_lookup(r, r2[9:0], r2[11:10], rand_mt());
            step();
        end
        end_test("direct");

        put_ctrl(ctrl_dmw0, 1'b0, 2'd0, make_dmw(1'b1, 1'b0, 2'd1, 3'd5, 3'd1));
        step();
        put_ctrl(ctrl_dmw1, 1'b0, 2'd0, make_dmw(1'b1, 1'b1, 2'd2, 3'd5, 3'd6));
        step();
        put_ctrl(ctrl_mode, 1'b0, 2'd3, '0);
        step();
        for (int i = 0; i < 80; i++) begin
            r  = rnd();
            r2 = rnd();
            if (i == 40) begin
                put_ctrl(ctrl_dmw1, 1'b0, 2'd0, make_dmw(1'b1, 1'b1, 2'd3, 3'd4, 3'd2));
            end
            // steer half the lookups into the configured segments
            if (r2[13]) begin
                r[31:29] = r2[14] ? 3'd5 : 3'd4;
            end
            put_lookup(r, r2[9:0], r2[11:10], rand_mt());
            step();
        end
        end_test("windows");

        put_ctrl(ctrl_dmw0, 1'b0, 2'd0, '0);
        step();
        put_ctrl(ctrl_dmw1, 1'b0, 2'd0, '0);
        step();
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            idx  = i[`MMU_TLB_IDX_W-1:0];
            done = 1'b0;
            for (int t = 0; t < 4 && !done; t++) begin
                load_entry(idx, rand_entry(), done);
            end
            if (!done) begin
                ent   = rand_entry();
                ent.e = 1'b0;
                load_entry(idx, ent, done);
            end
            step();
        end
        random_lookups(80, 1'b0);
        end_test("tlb_map");

        random_lookups(120, 1'b1);
        end_test("exceptions");

        read_all();
        put_inv(inv_asid, 10'd1, 32'd0);
        step();
        random_lookups(30, 1'b0);
        r = rnd();
        put_inv(inv_asid_va, shadow[r[3:0]].asid, addr_in(shadow[r[3:0]]));
        step();
        random_lookups(30, 1'b0);
        read_all();
        put_inv(inv_all, 10'd0, 32'd0);
        step();
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            shadow[i].e = 1'b0;
        end
        random_lookups(20, 1'b0);
        end_test("readback_inv");

        for (int i = 0; i < 8; i++) begin
            r           = rnd();
            idx         = r[3:0];
            ent         = rand_entry();
            ent.e       = 1'b1;
            ent.page0.v = 1'b1;
            ent.page1.v = 1'b1;
            load_entry(idx, ent, done);
            step();
            if (done) begin
                // same tags, new frames
                ent.page0.pfn = ~ent.page0.pfn;
                ent.page1.pfn = ~ent.page1.pfn;
                r2            = addr_in(ent);
                load_entry(idx, ent, done);
                put_lookup(r2, ent.asid, 2'd0, mem_load);
                step();
                put_lookup(r2, ent.asid, 2'd0, mem_load);
                step();
            end
        end
        end_test("write_bypass");

        $display("tlb writes skipped for overlap: %0d", skipped);
        chk.report_totals();
        if (err_total == 0 && chk_total > 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
src/mmu_pkg.sv
src/xlate_ctrl_regs.sv
src/tlb_entry_array.sv
src/tlb_match.sv
src/addr_translate.sv
src/mmu_top.sv
verif/mmu_checker.sv
verif/mmu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mmu_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
